//--- compile.f
logic/renamePkg.sv
logic/registerAliasTable.sv
logic/freeList.sv
logic/busyTable.sv
logic/renameStage.sv
logic/reorderBuffer.sv
logic/renameUnit.sv
dv/renameUnitTb.sv

//--- Makefile
BUILD = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f compile.f \
		--top-module renameUnitTb -Mdir $(BUILD) -o renameUnitTb

run: compile
	-./$(BUILD)/renameUnitTb > $(LOG) 2>&1
	cat $(LOG)
	@grep -q "Finished with no errors" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/renameUnitTb.sv
`timescale 1ns/1ps

module renameUnitTb;

    localparam int NUM_INSTRS     = 2000;
    localparam int TIMEOUT_CYCLES = NUM_INSTRS * 20;
    localparam int STALL_CYCLES   = 60;   // long enough to back the ROB up
    localparam int STALL_SPACING  = 250;

    logic                           CLK;
    logic                           RESET;
    logic                           instrValid;
    logic                           instrReady;
    renamePkg::decodedInstrT        instrIn;
    logic                           issueValid;
    logic                           issueReady;
    renamePkg::issueEntryT          issueEntry;
    logic                           lsqValid;
    logic                           lsqReady;
    renamePkg::lsqEntryT            lsqEntry;
    logic                           retireValid;
    logic                           retireReady;
    renamePkg::retireT              retireOut;
    logic                           wakeupValid;
    logic [renamePkg::LOG_PHYS-1:0] wakeupTag;

    // reference model state
    logic [renamePkg::LOG_PHYS-1:0] ratModel [renamePkg::NUM_ARCH_REGS];
    logic [renamePkg::LOG_PHYS-1:0] freeQ [$];
    bit                             busyModel [renamePkg::NUM_PHYS_REGS];
    renamePkg::retireT              robQ [$];
    logic [renamePkg::LOG_ROB-1:0]  robTail;
    logic                           issuePending;
    logic                           lsqPending;
    renamePkg::issueEntryT          issueExp;
    renamePkg::lsqEntryT            lsqExp;

    integer seed;
    int     acceptedCount;
    int     generated;
    int     fullSeen;
    int     stallLeft;
    int     stallCount;
    int     nextStallAt;
    bit     tagPressure;       // stall phase that only sends register writes
    bit     lastAccepted;

    renameUnit UUT (
        .CLK, .RESET,
        .instrValid, .instrReady, .instrIn,
        .issueValid, .issueReady, .issueEntry,
        .lsqValid, .lsqReady, .lsqEntry,
        .retireValid, .retireReady, .retireOut,
        .wakeupValid, .wakeupTag
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("Watchdog expired: the rename unit hung before all instructions retired");
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

    function automatic int uniformBelow(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic renamePkg::decodedInstrT randomInstr(bit writesOnly);
        renamePkg::decodedInstrT d;
        int kind;
        d.instr        = $random(seed);
        d.instrAddr    = $random(seed);
        d.altPc        = $random(seed);
        d.requestAltPc = 1'b0;
        d.readRegA     = 5'(uniformBelow(32));
        d.readRegB     = 5'(uniformBelow(32));
        d.writeReg     = 5'(uniformBelow(32));
        d.operandA     = $random(seed);
        d.operandB     = $random(seed);
        d.aluSrc       = 1'b0;
        d.aluControl   = 6'(uniformBelow(64));
        d.shiftAmount  = 5'(uniformBelow(32));
        d.regWrite     = 1'b0;
        d.memRead      = 1'b0;
        d.memWrite     = 1'b0;
        kind = writesOnly ? 0 : uniformBelow(10);
        if (kind < 4) begin                              // ALU
            d.regWrite = 1'b1;
            d.aluSrc   = (uniformBelow(2) == 1);
            if (writesOnly) begin
                d.writeReg = 5'(1 + uniformBelow(31));
            end
        end else if (kind < 6) begin                     // load
            d.regWrite = 1'b1;
            d.memRead  = 1'b1;
            d.aluSrc   = 1'b1;
        end else if (kind < 8) begin                     // store
            d.memWrite = 1'b1;
            d.aluSrc   = 1'b1;
        end else begin                                   // branch
            d.requestAltPc = (uniformBelow(2) == 1);
        end
        return d;
    endfunction

    // ready unless still waiting on a writeback or woken in this cycle
    function automatic logic sourceReady(logic [4:0] regNum,
                                         logic [renamePkg::LOG_PHYS-1:0] tag);
        return (regNum == '0) || !busyModel[tag] || (wakeupValid && (wakeupTag == tag));
    endfunction

    task automatic compareBit(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic compareIssue(string name, renamePkg::issueEntryT exp,
                                renamePkg::issueEntryT act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "issue entry mismatch");
        end
    endtask

    task automatic compareLsq(string name, renamePkg::lsqEntryT exp, renamePkg::lsqEntryT act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "lsq entry mismatch");
        end
    endtask

    task automatic compareRetire(string name, renamePkg::retireT exp, renamePkg::retireT act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "retire mismatch");
        end
    endtask

    task automatic resetModel();
        for (int i = 0; i < renamePkg::NUM_ARCH_REGS; i++) begin
            ratModel[i] = 6'(i);
        end
        for (int i = renamePkg::NUM_ARCH_REGS; i < renamePkg::NUM_PHYS_REGS; i++) begin
            freeQ.push_back(6'(i));                      // 32 upward
        end
        for (int i = 0; i < renamePkg::NUM_PHYS_REGS; i++) begin
            busyModel[i] = 1'b0;
        end
        robTail      = '0;
        issuePending = 1'b0;
        lsqPending   = 1'b0;
    endtask

    task automatic pickWakeup();
        logic [renamePkg::LOG_PHYS-1:0] busyTags [$];
        for (int t = 1; t < renamePkg::NUM_PHYS_REGS; t++) begin
            if (busyModel[t]) begin
                busyTags.push_back(6'(t));
            end
        end
        if ((busyTags.size() > 0) && (uniformBelow(100) < 40)) begin
            wakeupValid = 1'b1;
            wakeupTag   = busyTags[uniformBelow(busyTags.size())];
        end else begin
            wakeupValid = 1'b0;
        end
    endtask

    task automatic driveCycle();
        if ((stallLeft == 0) && (acceptedCount >= nextStallAt) && (nextStallAt < NUM_INSTRS)) begin
            stallLeft   = STALL_CYCLES;
            tagPressure = stallCount[0];
            stallCount++;
            nextStallAt += STALL_SPACING;
        end
        if (!instrValid || lastAccepted) begin          // hold until taken
            if ((generated < NUM_INSTRS) && (uniformBelow(100) < 85)) begin
                instrIn    = randomInstr(tagPressure && (stallLeft > 0));
                instrValid = 1'b1;
                generated++;
            end else begin
                instrValid = 1'b0;
            end
        end
        issueReady  = (uniformBelow(100) < 75);
        lsqReady    = (uniformBelow(100) < 75);
        retireReady = (stallLeft > 0) ? 1'b0 : (uniformBelow(100) < 70);
        if (stallLeft > 0) begin
            stallLeft--;
        end
        pickWakeup();
    endtask

    // sampled mid-cycle to apply what the next rising edge will do
    task automatic checkCycle();
        renamePkg::issueEntryT          expIssue;
        renamePkg::lsqEntryT            expLsq;
        renamePkg::retireT              expRetire;
        logic [renamePkg::LOG_PHYS-1:0] tagA;
        logic [renamePkg::LOG_PHYS-1:0] tagB;
        logic [renamePkg::LOG_PHYS-1:0] newTag;
        logic                           needTag;
        logic                           isMem;
        logic                           expReady;
        logic                           accept;
        needTag  = instrIn.regWrite && (instrIn.writeReg != '0);
        isMem    = instrIn.memRead || instrIn.memWrite;
        expReady = (!issuePending || issueReady) && (!lsqPending || lsqReady)
                   && (robQ.size() < renamePkg::ROB_DEPTH) && !(needTag && (freeQ.size() == 0));
        compareBit("instrReady", expReady, instrReady);
        compareBit("issueValid", issuePending, issueValid);
        compareBit("lsqValid", lsqPending, lsqValid);
        compareBit("retireValid", robQ.size() != 0, retireValid);
        if (robQ.size() == renamePkg::ROB_DEPTH) begin
            fullSeen++;
        end
        accept       = instrValid && instrReady;
        lastAccepted = accept;

        if (retireValid && retireReady) begin
            expRetire = robQ.pop_front();
            compareRetire("retire", expRetire, retireOut);
            if (expRetire.hasDest) begin
                freeQ.push_back(expRetire.oldTag);       // freed tags reused in retire order
            end
        end
        if (issueValid && issueReady) begin
            compareIssue("issue", issueExp, issueEntry);
        end
        if (lsqValid && lsqReady) begin
            compareLsq("lsq", lsqExp, lsqEntry);
        end

        if (accept) begin
            tagA   = (instrIn.readRegA == '0) ? '0 : ratModel[instrIn.readRegA];
            tagB   = (instrIn.readRegB == '0) ? '0 : ratModel[instrIn.readRegB];
            newTag = needTag ? freeQ.pop_front() : '0;
            expIssue.aluControl  = instrIn.aluControl;
            expIssue.srcTagA     = tagA;
            expIssue.srcOperandA = instrIn.operandA;
            expIssue.srcReadyA   = sourceReady(instrIn.readRegA, tagA);
            expIssue.srcTagB     = tagB;
            expIssue.srcOperandB = instrIn.operandB;
            expIssue.srcReadyB   = instrIn.aluSrc || sourceReady(instrIn.readRegB, tagB);
            expIssue.shiftAmount = instrIn.shiftAmount;
            expIssue.hasDest     = needTag;
            expIssue.destTag     = newTag;
            expIssue.memRead     = instrIn.memRead;
            expIssue.memWrite    = instrIn.memWrite;
            expIssue.robIndex    = robTail;
            expLsq.isStore  = instrIn.memWrite;
            expLsq.tag      = instrIn.memWrite ? tagA : newTag;
            expLsq.robIndex = robTail;
            expRetire.archReg = instrIn.writeReg;
            expRetire.newTag  = newTag;
            expRetire.oldTag  = needTag ? ratModel[instrIn.writeReg] : '0;
            expRetire.hasDest = needTag;
            robQ.push_back(expRetire);
            robTail      = robTail + 1'b1;
            issueExp     = expIssue;
            issuePending = 1'b1;
            lsqPending   = isMem;
            if (isMem) begin
                lsqExp = expLsq;
            end
            if (needTag) begin
                ratModel[instrIn.writeReg] = newTag;
            end
            acceptedCount++;
        end else begin
            if (issueReady) begin
                issuePending = 1'b0;
            end
            if (lsqReady) begin
                lsqPending = 1'b0;
            end
        end
        if (wakeupValid) begin
            busyModel[wakeupTag] = 1'b0;
        end
        if (accept && needTag) begin
            busyModel[newTag] = 1'b1;                    // set beats a wakeup of the same tag
        end
    endtask

    initial begin
        RESET         = 1'b0;
        instrValid    = 1'b0;
        instrIn       = '0;
        issueReady    = 1'b0;
        lsqReady      = 1'b0;
        retireReady   = 1'b0;
        wakeupValid   = 1'b0;
        wakeupTag     = '0;
        seed          = 65;
        acceptedCount = 0;
        generated     = 0;
        fullSeen      = 0;
        stallLeft     = 0;
        stallCount    = 0;
        nextStallAt   = 100;
        tagPressure   = 1'b0;
        lastAccepted  = 1'b0;
        resetModel();
        repeat (4) @(posedge CLK);
        #1 RESET = 1'b1;
        while (!((acceptedCount == NUM_INSTRS) && (robQ.size() == 0)
                 && !issuePending && !lsqPending)) begin
            @(posedge CLK);
            #1;
            driveCycle();
            @(negedge CLK);
            checkCycle();
        end
        if (fullSeen == 0) begin
            $display("The ROB never filled during the retire stall phases");
            $display("Finished with errors");
            $fatal(1, "stall phase not reached");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- logic/renameUnit.sv
`timescale 1ns/1ps

module renameUnit (
    input  logic                           CLK,
    input  logic                           RESET,
    input  logic                           instrValid,
    output logic                           instrReady,
    input  renamePkg::decodedInstrT        instrIn,
    output logic                           issueValid,
    input  logic                           issueReady,
    output renamePkg::issueEntryT          issueEntry,
    output logic                           lsqValid,
    input  logic                           lsqReady,
    output renamePkg::lsqEntryT            lsqEntry,
    output logic                           retireValid,
    input  logic                           retireReady,
    output renamePkg::retireT              retireOut,
    input  logic                           wakeupValid,
    input  logic [renamePkg::LOG_PHYS-1:0] wakeupTag
);

    logic [renamePkg::LOG_ARCH-1:0] readRegA;
    logic [renamePkg::LOG_ARCH-1:0] readRegB;
    logic [renamePkg::LOG_ARCH-1:0] readDest;
    logic [renamePkg::LOG_PHYS-1:0] tagA;
    logic [renamePkg::LOG_PHYS-1:0] tagB;
    logic [renamePkg::LOG_PHYS-1:0] oldTag;
    logic                           writeEn;
    logic [renamePkg::LOG_ARCH-1:0] writeReg;
    logic [renamePkg::LOG_PHYS-1:0] writeTag;
    logic                           popValid;
    logic                           pop;
    logic [renamePkg::LOG_PHYS-1:0] popTag;
    logic                           freePush;
    logic [renamePkg::LOG_PHYS-1:0] freeTag;
    logic                           busyA;
    logic                           busyB;
    logic                           setEn;
    logic [renamePkg::LOG_PHYS-1:0] setTag;
    logic                           robFull;
    logic                           robPush;
    logic [renamePkg::LOG_ROB-1:0]  robIndex;
    renamePkg::robEntryT            robEntry;

    registerAliasTable rat (
        .CLK, .RESET,
        .readRegA, .readRegB, .readDest,
        .tagA, .tagB, .oldTag,
        .writeEn, .writeReg, .writeTag
    );

    freeList freeRegs (
        .CLK, .RESET,
        .popValid, .pop, .popTag,
        .push(freePush), .pushTag(freeTag)
    );

    busyTable busy (
        .CLK, .RESET,
        .tagA, .tagB, .busyA, .busyB,        // read with the raw map tags
        .setEn, .setTag,
        .wakeupValid, .wakeupTag
    );

    renameStage stage (
        .CLK, .RESET,
        .instrValid, .instrReady, .instrIn,
        .readRegA, .readRegB, .readDest, .tagA, .tagB, .oldTag,
        .writeEn, .writeReg, .writeTag,
        .popValid, .pop, .popTag,
        .busyA, .busyB, .setEn, .setTag,
        .robFull, .robPush, .robIndex, .robEntry,
        .issueValid, .issueReady, .issueEntry,
        .lsqValid, .lsqReady, .lsqEntry
    );

    reorderBuffer rob (
        .CLK, .RESET,
        .push(robPush), .pushEntry(robEntry),
        .full(robFull), .tailIndex(robIndex),
        .retireValid, .retireReady, .retireOut,
        .freePush, .freeTag
    );

endmodule

//--- logic/reorderBuffer.sv
`timescale 1ns/1ps

module reorderBuffer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          push,
    input  renamePkg::robEntryT           pushEntry,
    output logic                          full,
    output logic [renamePkg::LOG_ROB-1:0] tailIndex,
    output logic                          retireValid,
    input  logic                          retireReady,
    output renamePkg::retireT             retireOut,
    output logic                          freePush,
    output logic [renamePkg::LOG_PHYS-1:0] freeTag
);

    renamePkg::robEntryT           entries [renamePkg::ROB_DEPTH];
    renamePkg::robEntryT           headEntry;
    logic [renamePkg::LOG_ROB-1:0] head;
    logic [renamePkg::LOG_ROB-1:0] tail;
    logic [renamePkg::LOG_ROB:0]   count;
    logic                          retire;

    assign headEntry   = entries[head];
    assign full        = (count == renamePkg::ROB_DEPTH[renamePkg::LOG_ROB:0]);
    assign tailIndex   = tail;               // index the next push will take
    assign retireValid = (count != '0);
    assign retire      = retireValid && retireReady;

    assign retireOut.archReg = headEntry.archReg;
    assign retireOut.newTag  = headEntry.newTag;
    assign retireOut.oldTag  = headEntry.oldTag;
    assign retireOut.hasDest = headEntry.hasDest;

    // previous mapping is dead once its overwriter commits
    assign freePush = retire && headEntry.hasDest;
    assign freeTag  = headEntry.oldTag;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({push, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            entries[tail] <= pushEntry;
        end
    end

endmodule

//--- logic/renameStage.sv
`timescale 1ns/1ps

module renameStage (
    input  logic                           CLK,
    input  logic                           RESET,
    input  logic                           instrValid,
    output logic                           instrReady,
    input  renamePkg::decodedInstrT        instrIn,
    output logic [renamePkg::LOG_ARCH-1:0] readRegA,
    output logic [renamePkg::LOG_ARCH-1:0] readRegB,
    output logic [renamePkg::LOG_ARCH-1:0] readDest,
    input  logic [renamePkg::LOG_PHYS-1:0] tagA,
    input  logic [renamePkg::LOG_PHYS-1:0] tagB,
    input  logic [renamePkg::LOG_PHYS-1:0] oldTag,
    output logic                           writeEn,
    output logic [renamePkg::LOG_ARCH-1:0] writeReg,
    output logic [renamePkg::LOG_PHYS-1:0] writeTag,
    input  logic                           popValid,
    output logic                           pop,
    input  logic [renamePkg::LOG_PHYS-1:0] popTag,
    input  logic                           busyA,
    input  logic                           busyB,
    output logic                           setEn,
    output logic [renamePkg::LOG_PHYS-1:0] setTag,
    input  logic                           robFull,
    output logic                           robPush,
    input  logic [renamePkg::LOG_ROB-1:0]  robIndex,
    output renamePkg::robEntryT            robEntry,
    output logic                           issueValid,
    input  logic                           issueReady,
    output renamePkg::issueEntryT          issueEntry,
    output logic                           lsqValid,
    input  logic                           lsqReady,
    output renamePkg::lsqEntryT            lsqEntry
);

    logic                           started;    // first edge after reset seen
    logic                           needTag;
    logic                           isMem;
    logic                           outFree;
    logic                           blocked;
    logic                           accept;
    logic [renamePkg::LOG_PHYS-1:0] srcTagA;
    logic [renamePkg::LOG_PHYS-1:0] srcTagB;
    logic [renamePkg::LOG_PHYS-1:0] destTag;
    renamePkg::issueEntryT          issueNext;
    renamePkg::lsqEntryT            lsqNext;

    assign needTag = instrIn.regWrite && (instrIn.writeReg != '0);
    assign isMem   = instrIn.memRead || instrIn.memWrite;
    assign outFree = (!issueValid || issueReady) && (!lsqValid || lsqReady);

    always_comb begin
        blocked = 1'b0;
        if (!started) begin
            blocked = 1'b1;
        end else if (!outFree) begin
            blocked = 1'b1;                  // previous instruction not yet taken
        end else if (robFull) begin
            blocked = 1'b1;
        end else if (needTag && !popValid) begin
            blocked = 1'b1;                  // waiting for a free physical register
        end
    end

    assign instrReady = !blocked;
    assign accept     = instrValid && instrReady;

    // map lookups
    assign readRegA = instrIn.readRegA;
    assign readRegB = instrIn.readRegB;
    assign readDest = instrIn.writeReg;
    assign srcTagA  = (instrIn.readRegA == '0) ? '0 : tagA;
    assign srcTagB  = (instrIn.readRegB == '0) ? '0 : tagB;
    assign destTag  = needTag ? popTag : '0;

    assign pop      = accept && needTag;
    assign writeEn  = pop;
    assign writeReg = instrIn.writeReg;
    assign writeTag = popTag;
    assign setEn    = pop;                   // new destination is pending until wakeup
    assign setTag   = popTag;
    assign robPush  = accept;

    always_comb begin
        issueNext.aluControl  = instrIn.aluControl;
        issueNext.srcTagA     = srcTagA;
        issueNext.srcOperandA = instrIn.operandA;
        issueNext.srcReadyA   = (instrIn.readRegA == '0) || !busyA;
        issueNext.srcTagB     = srcTagB;
        issueNext.srcOperandB = instrIn.operandB;
        issueNext.srcReadyB   = instrIn.aluSrc || (instrIn.readRegB == '0) || !busyB;
        issueNext.shiftAmount = instrIn.shiftAmount;
        issueNext.hasDest     = needTag;
        issueNext.destTag     = destTag;
        issueNext.memRead     = instrIn.memRead;
        issueNext.memWrite    = instrIn.memWrite;
        issueNext.robIndex    = robIndex;

        lsqNext.isStore  = instrIn.memWrite;
        lsqNext.tag      = instrIn.memWrite ? srcTagA : destTag; // store keys on its base
        lsqNext.robIndex = robIndex;

        robEntry.instr        = instrIn.instr;
        robEntry.instrAddr    = instrIn.instrAddr;
        robEntry.altPc        = instrIn.altPc;
        robEntry.requestAltPc = instrIn.requestAltPc;
        robEntry.hasDest      = needTag;
        robEntry.archReg      = instrIn.writeReg;
        robEntry.newTag       = destTag;
        robEntry.oldTag       = needTag ? oldTag : '0;
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            started    <= 1'b0;
            issueValid <= 1'b0;
            lsqValid   <= 1'b0;
        end else begin
            started <= 1'b1;
            if (accept) begin
                issueValid <= 1'b1;
                lsqValid   <= isMem;
            end else begin
                if (issueReady) begin
                    issueValid <= 1'b0;
                end
                if (lsqReady) begin
                    lsqValid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            issueEntry <= issueNext;
        end
        if (accept && isMem) begin
            lsqEntry <= lsqNext;
        end
    end

endmodule

//--- logic/busyTable.sv
`timescale 1ns/1ps

module busyTable (
    input  logic                           CLK,
    input  logic                           RESET,
    input  logic [renamePkg::LOG_PHYS-1:0] tagA,
    input  logic [renamePkg::LOG_PHYS-1:0] tagB,
    output logic                           busyA,
    output logic                           busyB,
    input  logic                           setEn,
    input  logic [renamePkg::LOG_PHYS-1:0] setTag,
    input  logic                           wakeupValid,
    input  logic [renamePkg::LOG_PHYS-1:0] wakeupTag
);

    logic [renamePkg::NUM_PHYS_REGS-1:0] busy;

    // a wakeup in the same cycle makes the read see the value as ready
    assign busyA = busy[tagA] && !(wakeupValid && (wakeupTag == tagA));
    assign busyB = busy[tagB] && !(wakeupValid && (wakeupTag == tagB));

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            busy <= '0;
        end else begin
            if (wakeupValid) begin
                busy[wakeupTag] <= 1'b0;
            end
            if (setEn && (setTag != '0)) begin
                busy[setTag] <= 1'b1;        // tag 0 stays ready forever
            end
        end
    end

endmodule

//--- logic/freeList.sv
`timescale 1ns/1ps

module freeList (
    input  logic                           CLK,
    input  logic                           RESET,
    output logic                           popValid,
    input  logic                           pop,
    output logic [renamePkg::LOG_PHYS-1:0] popTag,
    input  logic                           push,
    input  logic [renamePkg::LOG_PHYS-1:0] pushTag
);

    logic [renamePkg::LOG_PHYS-1:0] tagFifo [renamePkg::FREE_DEPTH];
    logic [renamePkg::LOG_FREE-1:0] head;
    logic [renamePkg::LOG_FREE-1:0] tail;
    logic [renamePkg::LOG_FREE:0]   count;

    assign popValid = (count != '0);
    assign popTag   = tagFifo[head];

    // at most 32 tags are ever free at once, so a push never meets a full list
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < renamePkg::FREE_DEPTH; i++) begin
                tagFifo[i] <= {1'b1, i[renamePkg::LOG_FREE-1:0]}; // tags 32..63
            end
            head  <= '0;
            tail  <= '0;                     // wrapped, list starts full
            count <= {1'b1, {renamePkg::LOG_FREE{1'b0}}};
        end else begin
            if (pop) begin
                head <= head + 1'b1;
            end
            if (push) begin
                tagFifo[tail] <= pushTag;    // retired tags join in retire order
                tail          <= tail + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/registerAliasTable.sv
`timescale 1ns/1ps

module registerAliasTable (
    input  logic                           CLK,
    input  logic                           RESET,
    input  logic [renamePkg::LOG_ARCH-1:0] readRegA,
    input  logic [renamePkg::LOG_ARCH-1:0] readRegB,
    input  logic [renamePkg::LOG_ARCH-1:0] readDest,
    output logic [renamePkg::LOG_PHYS-1:0] tagA,
    output logic [renamePkg::LOG_PHYS-1:0] tagB,
    output logic [renamePkg::LOG_PHYS-1:0] oldTag,
    input  logic                           writeEn,
    input  logic [renamePkg::LOG_ARCH-1:0] writeReg,
    input  logic [renamePkg::LOG_PHYS-1:0] writeTag
);

    // speculative mapping, updated at every rename that writes a register
    logic [renamePkg::LOG_PHYS-1:0] mapTable [renamePkg::NUM_ARCH_REGS];

    assign tagA   = mapTable[readRegA];
    assign tagB   = mapTable[readRegB];
    assign oldTag = mapTable[readDest];      // mapping about to be replaced

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < renamePkg::NUM_ARCH_REGS; i++) begin
                mapTable[i] <= i[renamePkg::LOG_PHYS-1:0]; // identity map
            end
        end else if (writeEn) begin
            mapTable[writeReg] <= writeTag;
        end
    end

endmodule

//--- logic/renamePkg.sv
package renamePkg;

    localparam int NUM_ARCH_REGS = 32;
    localparam int LOG_ARCH      = 5;
    localparam int NUM_PHYS_REGS = 64;
    localparam int LOG_PHYS      = 6;
    localparam int ROB_DEPTH     = 16;
    localparam int LOG_ROB       = 4;
    localparam int FREE_DEPTH    = NUM_PHYS_REGS - NUM_ARCH_REGS; // tags not held by the map
    localparam int LOG_FREE      = 5;

    // instruction as it leaves decode
    typedef struct packed {
        logic [31:0]         instr;
        logic [31:0]         instrAddr;
        logic [31:0]         altPc;
        logic                requestAltPc;
        logic [LOG_ARCH-1:0] readRegA;
        logic [LOG_ARCH-1:0] readRegB;
        logic [LOG_ARCH-1:0] writeReg;
        logic [31:0]         operandA;
        logic [31:0]         operandB;
        logic                aluSrc;         // operand B is an immediate
        logic [5:0]          aluControl;
        logic [4:0]          shiftAmount;
        logic                regWrite;
        logic                memRead;        // load
        logic                memWrite;       // store
    } decodedInstrT;

    typedef struct packed {
        logic [5:0]          aluControl;
        logic [LOG_PHYS-1:0] srcTagA;
        logic [31:0]         srcOperandA;
        logic                srcReadyA;
        logic [LOG_PHYS-1:0] srcTagB;
        logic [31:0]         srcOperandB;
        logic                srcReadyB;
        logic [4:0]          shiftAmount;
        logic                hasDest;
        logic [LOG_PHYS-1:0] destTag;
        logic                memRead;
        logic                memWrite;
        logic [LOG_ROB-1:0]  robIndex;
    } issueEntryT;

    typedef struct packed {
        logic                isStore;
        logic [LOG_PHYS-1:0] tag;            // dest tag of a load, base tag of a store
        logic [LOG_ROB-1:0]  robIndex;
    } lsqEntryT;

    typedef struct packed {
        logic [31:0]         instr;
        logic [31:0]         instrAddr;
        logic [31:0]         altPc;          // carried only, no recovery yet
        logic                requestAltPc;
        logic                hasDest;
        logic [LOG_ARCH-1:0] archReg;
        logic [LOG_PHYS-1:0] newTag;
        logic [LOG_PHYS-1:0] oldTag;         // freed when this entry retires
    } robEntryT;

    typedef struct packed {
        logic [LOG_ARCH-1:0] archReg;
        logic [LOG_PHYS-1:0] newTag;
        logic [LOG_PHYS-1:0] oldTag;
        logic                hasDest;
    } retireT;

endpackage
